// ==== design/cim_config.svh ====
//*************************************************
// geometry of the cim word array and the host bus
// include wherever a width or the row count is needed
//*************************************************
`ifndef CIM_CONFIG_SVH
`define CIM_CONFIG_SVH

// bits per row, also the avalon data width
`define CIM_WORD_WIDTH 32

// row address, as carried in the instruction fields
`define CIM_ADDR_WIDTH 8

// number of rows in the array
`define CIM_DEPTH 256

// avalon word address
// top bit set means a row load, clear means an instruction
`define CIM_HOST_ADDR_WIDTH 9

`endif

// ==== design/cim_pkg.sv ====
//*************************************************
// shared types for the cim word array
// opcodes, instruction views, alu control and bus structs
//*************************************************
`include "cim_config.svh"

package cim_pkg;

    // instruction opcodes, byte 31:24 of a command word
    typedef enum logic [7:0] {
        MOVE  = 8'h01,
        ORC   = 8'h03,
        ANDC  = 8'h04,
        XORC  = 8'h05,
        LSHFT = 8'h08,
        RSHFT = 8'h09,
        PINV  = 8'h0E,
        ADDS  = 8'h0F,
        SCIN  = 8'h10
    } cim_opcode_e;

    // single-row form, move / invert / shifts / scin
    typedef struct packed {
        cim_opcode_e                 opcode;
        logic [`CIM_ADDR_WIDTH-1:0]  src;
        logic [`CIM_ADDR_WIDTH-1:0]  dst;
        logic [2:0]                  rsvd;
        logic [4:0]                  shamt;
    } cim_cmd_single_t;

    // two-row form, or / and / xor / add
    typedef struct packed {
        cim_opcode_e                 opcode;
        logic [`CIM_ADDR_WIDTH-1:0]  src_a;
        logic [`CIM_ADDR_WIDTH-1:0]  src_b;
        logic [`CIM_ADDR_WIDTH-1:0]  dst;
    } cim_cmd_dual_t;

    // one command word, read through whichever view the opcode calls for
    typedef union packed {
        cim_cmd_single_t single;
        cim_cmd_dual_t   dual;
    } cim_cmd_u;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_NOT,
        ALU_SHL,
        ALU_SHR,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_ADD
    } cim_alu_op_e;

    typedef struct packed {
        cim_alu_op_e op;
        logic [4:0]  shamt;
        logic        carry_load;
        logic        carry_value;
        logic        carry_update;
    } cim_alu_ctrl_t;

    // registered row reads plus the two-row sense results
    typedef struct packed {
        logic [`CIM_WORD_WIDTH-1:0] row_a;
        logic [`CIM_WORD_WIDTH-1:0] row_b;
        logic [`CIM_WORD_WIDTH-1:0] and_word;
        logic [`CIM_WORD_WIDTH-1:0] or_word;
    } cim_sense_t;

    // port a only uses addr
    typedef struct packed {
        logic [`CIM_ADDR_WIDTH-1:0] addr;
        logic [`CIM_WORD_WIDTH-1:0] wdata;
        logic                       wren;
    } cim_port_t;

    typedef struct packed {
        logic [`CIM_HOST_ADDR_WIDTH-1:0] address;
        logic [`CIM_WORD_WIDTH-1:0]      writedata;
        logic                            write;
        logic                            read;
    } avmm_req_t;

    typedef struct packed {
        logic [`CIM_WORD_WIDTH-1:0] readdata;
        logic                       readdatavalid;
        logic                       waitrequest;
    } avmm_rsp_t;

endpackage

// ==== design/cim_sequencer.sv ====
//*************************************************
// control FSM for the cim array
// takes avalon transfers, then sequences the array ports
// and the row alu through load, read and instruction paths
//*************************************************
`timescale 1ns/1ps
`include "cim_config.svh"

module cim_sequencer (
    input  logic                             sys_clk_in,
    input  logic                             sys_reset_in,
    input  cim_pkg::avmm_req_t               host_req,
    output cim_pkg::avmm_rsp_t               host_rsp,
    output cim_pkg::cim_port_t               port_a,
    output cim_pkg::cim_port_t               port_b,
    output cim_pkg::cim_alu_ctrl_t           alu_ctrl,
    input  logic [`CIM_WORD_WIDTH-1:0]       alu_result,
    input  logic [`CIM_WORD_WIDTH-1:0]       readback
);
    import cim_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SETUP,
        ST_EVAL,
        ST_WRITE,
        ST_SHORT,
        ST_READ_1,
        ST_READ_2,
        ST_READ_3
    } seq_state_e;

    seq_state_e                  state, next_state;
    cim_cmd_u                    cmd_q, next_cmd;
    cim_cmd_u                    host_cmd;
    logic [`CIM_ADDR_WIDTH-1:0]  addr_a_q, next_addr_a;
    logic [`CIM_ADDR_WIDTH-1:0]  addr_b_q, next_addr_b;
    logic                        wren_b_q, next_wren_b;
    logic [`CIM_WORD_WIDTH-1:0]  load_word_q, next_load_word;
    cim_alu_ctrl_t               alu_q, next_alu;
    logic [`CIM_WORD_WIDTH-1:0]  readdata_q, next_readdata;
    logic                        rdv_q, next_rdv;
    logic                        waitreq_q, next_waitreq;
    logic                        accept;
    logic                        cmd_is_dual;
    cim_alu_op_e                 op_decoded;

    // avalon transfer completes when waitrequest is low
    assign accept   = (host_req.write || host_req.read) && !waitreq_q;
    assign host_cmd = host_req.writedata;

    // opcode picks the field view and the alu function
    always_comb
    begin
        cmd_is_dual = 1'b0;
        op_decoded  = ALU_PASS;
        case (cmd_q.single.opcode)
            PINV:  op_decoded = ALU_NOT;
            LSHFT: op_decoded = ALU_SHL;
            RSHFT: op_decoded = ALU_SHR;
            ORC:
            begin
                cmd_is_dual = 1'b1;
                op_decoded  = ALU_OR;
            end
            ANDC:
            begin
                cmd_is_dual = 1'b1;
                op_decoded  = ALU_AND;
            end
            XORC:
            begin
                cmd_is_dual = 1'b1;
                op_decoded  = ALU_XOR;
            end
            ADDS:
            begin
                cmd_is_dual = 1'b1;
                op_decoded  = ALU_ADD;
            end
            default: op_decoded = ALU_PASS;
        endcase
    end

    always_comb
    begin
        next_state          = state;
        next_cmd            = cmd_q;
        next_addr_a         = addr_a_q;
        next_addr_b         = addr_b_q;
        next_wren_b         = 1'b0;
        next_load_word      = load_word_q;
        next_alu            = alu_q;
        next_alu.carry_load   = 1'b0;
        next_alu.carry_update = 1'b0;
        next_readdata       = readdata_q;
        next_rdv            = 1'b0;
        next_waitreq        = waitreq_q;
        case (state)
            ST_IDLE:
            begin
                // one idle cycle after each operation before waitrequest drops
                next_waitreq = 1'b0;
                if (accept)
                begin
                    next_waitreq = 1'b1;
                    if (host_req.write && host_req.address[`CIM_HOST_ADDR_WIDTH-1])
                    begin
                        // row load, written straight from the host word
                        next_addr_b    = host_req.address[`CIM_ADDR_WIDTH-1:0];
                        next_load_word = host_req.writedata;
                        next_wren_b    = 1'b1;
                        next_state     = ST_LOAD;
                    end
                    else if (host_req.write)
                    begin
                        next_cmd = host_cmd;
                        case (host_cmd.single.opcode)
                            MOVE, PINV, LSHFT, RSHFT, ORC, ANDC, XORC, ADDS:
                                next_state = ST_SETUP;
                            // scin and unknown opcodes skip the array
                            default:
                                next_state = ST_SHORT;
                        endcase
                    end
                    else
                    begin
                        next_addr_a = host_req.address[`CIM_ADDR_WIDTH-1:0];
                        next_state  = ST_READ_1;
                    end
                end
            end
            ST_LOAD:
                next_state = ST_IDLE;
            ST_SETUP:
            begin
                next_alu.op    = op_decoded;
                next_alu.shamt = cmd_q.single.shamt;
                if (cmd_is_dual)
                begin
                    next_addr_a = cmd_q.dual.src_a;
                    next_addr_b = cmd_q.dual.src_b;
                end
                else
                begin
                    next_addr_a = cmd_q.single.src;
                    next_addr_b = cmd_q.single.src;
                end
                next_state = ST_EVAL;
            end
            ST_EVAL:
            begin
                // sense data lands at the end of this cycle
                // port b swaps to dst only after it has sampled src_b
                next_addr_b = cmd_is_dual ? cmd_q.dual.dst : cmd_q.single.dst;
                next_wren_b = 1'b1;
                next_alu.carry_update = (cmd_q.single.opcode == ADDS);
                next_state  = ST_WRITE;
            end
            ST_WRITE:
                next_state = ST_IDLE;
            ST_SHORT:
            begin
                // carry comes from the lsb of the src field
                next_alu.carry_load  = (cmd_q.single.opcode == SCIN);
                next_alu.carry_value = cmd_q.single.src[0];
                next_state = ST_IDLE;
            end
            ST_READ_1:
                next_state = ST_READ_2;
            ST_READ_2:
                next_state = ST_READ_3;
            ST_READ_3:
            begin
                next_readdata = readback;
                next_rdv      = 1'b1;
                next_waitreq  = 1'b0;
                next_state    = ST_IDLE;
            end
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            state     <= ST_IDLE;
            wren_b_q  <= 1'b0;
            alu_q     <= '0;
            rdv_q     <= 1'b0;
            waitreq_q <= 1'b1;
        end
        else
        begin
            state     <= next_state;
            wren_b_q  <= next_wren_b;
            alu_q     <= next_alu;
            rdv_q     <= next_rdv;
            waitreq_q <= next_waitreq;
        end
    end

    // command and data registers
    always_ff @(posedge sys_clk_in)
    begin
        cmd_q       <= next_cmd;
        addr_a_q    <= next_addr_a;
        addr_b_q    <= next_addr_b;
        load_word_q <= next_load_word;
        readdata_q  <= next_readdata;
    end

    // port b takes the host word on a load, the alu result otherwise
    assign port_a   = '{addr: addr_a_q, wdata: '0, wren: 1'b0};
    assign port_b   = '{addr: addr_b_q,
                        wdata: (state == ST_LOAD) ? load_word_q : alu_result,
                        wren: wren_b_q};
    assign alu_ctrl = alu_q;
    assign host_rsp = '{readdata: readdata_q, readdatavalid: rdv_q, waitrequest: waitreq_q};

    // a write must never still be pending once back in idle
    a_no_write_in_idle: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        (state == ST_IDLE) |-> !wren_b_q)
        else $error("port b write active in idle");

    // one readdatavalid pulse per read
    a_rdv_single: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        rdv_q |=> !rdv_q)
        else $error("readdatavalid held for two cycles");

endmodule

// ==== design/cim_array.sv ====
//*************************************************
// dual-port row memory of the cim array
// both ports read with one cycle of latency, port b writes
// the two rows read together give the and/or sense words
//*************************************************
`timescale 1ns/1ps
`include "cim_config.svh"

module cim_array (
    input  logic                  sys_clk_in,
    input  cim_pkg::cim_port_t    port_a,
    input  cim_pkg::cim_port_t    port_b,
    output cim_pkg::cim_sense_t   sense
);

    // row storage
    logic [`CIM_WORD_WIDTH-1:0] mem [`CIM_DEPTH];

    // sensed rows, registered
    logic [`CIM_WORD_WIDTH-1:0] row_a_q;
    logic [`CIM_WORD_WIDTH-1:0] row_b_q;

    // read before write on port b
    // a row written and read in the same cycle returns old data
    always_ff @(posedge sys_clk_in)
    begin
        row_a_q <= mem[port_a.addr];
        row_b_q <= mem[port_b.addr];
        if (port_b.wren)
        begin
            mem[port_b.addr] <= port_b.wdata;
        end
    end

    // two wordlines active on shared bitlines
    // a bitline stays high only if both cells hold 1 (and)
    // the complement line drops if either cell holds 1 (or)
    assign sense.row_a    = row_a_q;
    assign sense.row_b    = row_b_q;
    assign sense.and_word = row_a_q & row_b_q;
    assign sense.or_word  = row_a_q | row_b_q;

    // no write may land on an undefined row
    a_write_addr_known: assert property (@(posedge sys_clk_in)
        port_b.wren |-> !$isunknown(port_b.addr))
        else $error("port b write with unknown address");

endmodule

// ==== design/cim_row_alu.sv ====
//*************************************************
// row alu of the cim array
// builds the result word for each instruction from the
// sensed rows and keeps the add carry flag
//*************************************************
`timescale 1ns/1ps
`include "cim_config.svh"

module cim_row_alu (
    input  logic                          sys_clk_in,
    input  logic                          sys_reset_in,
    input  cim_pkg::cim_alu_ctrl_t        alu_ctrl,
    input  cim_pkg::cim_sense_t           sense,
    output logic [`CIM_WORD_WIDTH-1:0]    result
);
    import cim_pkg::*;

    // carry flag between adds
    logic                        carry_q;
    // one extra bit for carry out
    logic [`CIM_WORD_WIDTH:0]    sum;

    assign sum = {1'b0, sense.row_a}
               + {1'b0, sense.row_b}
               + {{`CIM_WORD_WIDTH{1'b0}}, carry_q};

    always_comb
    begin
        case (alu_ctrl.op)
            ALU_PASS:
                result = sense.row_a;
            ALU_NOT:
                result = ~sense.row_a;
            // logical shifts, zero fill
            ALU_SHL:
                result = sense.row_a << alu_ctrl.shamt;
            ALU_SHR:
                result = sense.row_a >> alu_ctrl.shamt;
            ALU_OR:
                result = sense.or_word;
            ALU_AND:
                result = sense.and_word;
            // xor is or with the and bits knocked out
            ALU_XOR:
                result = sense.or_word & ~sense.and_word;
            ALU_ADD:
                result = sum[`CIM_WORD_WIDTH-1:0];
            default:
                result = sense.row_a;
        endcase
    end

    // scin loads the flag
    // adds update it as the result is written
    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            carry_q <= 1'b0;
        end
        else if (alu_ctrl.carry_load)
        begin
            carry_q <= alu_ctrl.carry_value;
        end
        else if (alu_ctrl.carry_update)
        begin
            carry_q <= sum[`CIM_WORD_WIDTH];
        end
    end

    // load and update come from different instructions
    a_carry_exclusive: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        !(alu_ctrl.carry_load && alu_ctrl.carry_update))
        else $error("carry load and carry update together");

endmodule

// ==== design/cim_top.sv ====
//*************************************************
// top of the cim word array
// avalon-mm slave in front of the FSM, the row memory
// and the row alu
//*************************************************
`timescale 1ns/1ps
`include "cim_config.svh"

module cim_top (
    input  logic                              sys_clk_in,
    input  logic                              sys_reset_in,
    input  logic [`CIM_HOST_ADDR_WIDTH-1:0]   avalon_address,
    input  logic [`CIM_WORD_WIDTH-1:0]        avalon_writedata,
    input  logic                              avalon_write,
    input  logic                              avalon_read,
    output logic [`CIM_WORD_WIDTH-1:0]        avalon_readdata,
    output logic                              avalon_readdatavalid,
    output logic                              avalon_waitrequest
);
    import cim_pkg::*;

    avmm_req_t                   host_req;
    avmm_rsp_t                   host_rsp;
    cim_port_t                   port_a;
    cim_port_t                   port_b;
    cim_alu_ctrl_t               alu_ctrl;
    cim_sense_t                  sense;
    logic [`CIM_WORD_WIDTH-1:0]  alu_result;

    // avalon pins to bus structs
    assign host_req = '{address: avalon_address, writedata: avalon_writedata,
                        write: avalon_write, read: avalon_read};
    assign avalon_readdata      = host_rsp.readdata;
    assign avalon_readdatavalid = host_rsp.readdatavalid;
    assign avalon_waitrequest   = host_rsp.waitrequest;

    cim_sequencer cim_sequencer_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .port_a       (port_a),
        .port_b       (port_b),
        .alu_ctrl     (alu_ctrl),
        .alu_result   (alu_result),
        // host reads come back through port a
        .readback     (sense.row_a)
    );

    cim_array cim_array_i (
        .sys_clk_in (sys_clk_in),
        .port_a     (port_a),
        .port_b     (port_b),
        .sense      (sense)
    );

    cim_row_alu cim_row_alu_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .alu_ctrl     (alu_ctrl),
        .sense        (sense),
        .result       (alu_result)
    );

endmodule

// ==== sim/cim_tb.sv ====
//*************************************************
// directed testbench for the cim word array
// drives the avalon port and checks every result
// against a row model kept in the testbench
//*************************************************
`timescale 1ns/1ps
`include "cim_config.svh"

module cim_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int DEPTH        = `CIM_DEPTH;
    localparam int N_LOADS      = 16;
    localparam int N_SINGLE     = 6;
    localparam int N_DUAL       = 6;
    localparam int N_UNKNOWN    = 4;
    localparam int STALL_LIMIT  = 32;
    localparam int RDV_LIMIT    = 16;
    localparam logic [31:0] SEED = 32'h43ce2ce7;
    // host operations per test, in test order
    localparam int TOTAL_OPS = (DEPTH + 2 * N_LOADS) + (4 * N_SINGLE * 3)
                             + (3 * N_DUAL * 2) + 13 + (7 + N_UNKNOWN * 4);
    localparam int WATCHDOG_NS = (TOTAL_OPS * 10 + RESET_CYCLES) * CLK_PERIOD;

    // opcodes as the instruction set defines them
    localparam logic [7:0] OP_MOVE  = 8'h01;
    localparam logic [7:0] OP_ORC   = 8'h03;
    localparam logic [7:0] OP_ANDC  = 8'h04;
    localparam logic [7:0] OP_XORC  = 8'h05;
    localparam logic [7:0] OP_LSHFT = 8'h08;
    localparam logic [7:0] OP_RSHFT = 8'h09;
    localparam logic [7:0] OP_PINV  = 8'h0E;
    localparam logic [7:0] OP_ADDS  = 8'h0F;
    localparam logic [7:0] OP_SCIN  = 8'h10;

    typedef logic [`CIM_WORD_WIDTH-1:0] word_t;
    typedef logic [`CIM_ADDR_WIDTH-1:0] row_t;

    logic                            sys_clk_in;
    logic                            sys_reset_in;
    logic [`CIM_HOST_ADDR_WIDTH-1:0] avalon_address;
    word_t                           avalon_writedata;
    logic                            avalon_write;
    logic                            avalon_read;
    word_t                           avalon_readdata;
    logic                            avalon_readdatavalid;
    logic                            avalon_waitrequest;

    // reference model of the array and the carry flag
    word_t model_rows [DEPTH];
    logic  model_carry;

    int   errors = 0;
    int   checks = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   reads_issued = 0;
    int   rdv_pulses = 0;
    int   last_stall = 0;
    logic reset_waitreq;

    cim_top cim_top_i (
        .sys_clk_in           (sys_clk_in),
        .sys_reset_in         (sys_reset_in),
        .avalon_address       (avalon_address),
        .avalon_writedata     (avalon_writedata),
        .avalon_write         (avalon_write),
        .avalon_read          (avalon_read),
        .avalon_readdata      (avalon_readdata),
        .avalon_readdatavalid (avalon_readdatavalid),
        .avalon_waitrequest   (avalon_waitrequest)
    );

    initial
    begin
        sys_clk_in = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2);
            sys_clk_in = ~sys_clk_in;
        end
    end

    // counts readdatavalid pulses, sampled mid-cycle
    always @(negedge sys_clk_in)
    begin
        if (avalon_readdatavalid === 1'b1)
            rdv_pulses++;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("Error at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("Error at %0d ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // called at a falling edge with the request already driven
    // returns at the falling edge after the accepting edge
    task automatic wait_accept();
        int stall;
        stall = 0;
        while (avalon_waitrequest !== 1'b0 && stall < STALL_LIMIT)
        begin
            @(negedge sys_clk_in);
            stall++;
        end
        last_stall = stall;
        checks++;
        assert (avalon_waitrequest === 1'b0)
        else
        begin
            $display("request at %0d ns was never accepted, waitrequest stayed high", $time);
            errors++;
        end
        @(negedge sys_clk_in);
    endtask

    task automatic host_write(input logic [`CIM_HOST_ADDR_WIDTH-1:0] addr, input word_t data);
        avalon_address   = addr;
        avalon_writedata = data;
        avalon_write     = 1'b1;
        wait_accept();
        avalon_write     = 1'b0;
    endtask

    task automatic read_row(input row_t row, output word_t data);
        int n;
        avalon_address = {1'b0, row};
        avalon_read    = 1'b1;
        reads_issued++;
        wait_accept();
        avalon_read    = 1'b0;
        n = 0;
        while (avalon_readdatavalid !== 1'b1 && n < RDV_LIMIT)
        begin
            @(negedge sys_clk_in);
            n++;
        end
        data = avalon_readdata;
        checks++;
        assert (avalon_readdatavalid === 1'b1)
        else
        begin
            $display("read of row %0d got no readdatavalid at %0d ns", row, $time);
            errors++;
        end
        @(negedge sys_clk_in);
        check_bit("avalon_readdatavalid one cycle later", 1'b0, avalon_readdatavalid);
    endtask

    task automatic check_row(input row_t row);
        word_t data;
        read_row(row, data);
        check_word($sformatf("avalon_readdata row %0d", row), model_rows[row], data);
    endtask

    // row load, host address bit 8 set
    task automatic load_row(input row_t row, input word_t data);
        host_write({1'b1, row}, data);
        model_rows[row] = data;
    endtask

    function automatic word_t single_result(input logic [7:0] op, input word_t value,
                                            input logic [4:0] shamt);
        case (op)
            OP_PINV:  return ~value;
            OP_LSHFT: return value << shamt;
            OP_RSHFT: return value >> shamt;
            default:  return value;
        endcase
    endfunction

    // single view: op, src, dst, 3 reserved bits, shamt
    task automatic issue_single(input logic [7:0] op, input row_t src, input row_t dst,
                                input logic [4:0] shamt);
        host_write('0, {op, src, dst, 3'b000, shamt});
        model_rows[dst] = single_result(op, model_rows[src], shamt);
    endtask

    // dual view: op, src_a, src_b, dst
    task automatic issue_dual(input logic [7:0] op, input row_t a, input row_t b,
                              input row_t dst);
        logic [`CIM_WORD_WIDTH:0] sum;
        host_write('0, {op, a, b, dst});
        sum = {1'b0, model_rows[a]} + {1'b0, model_rows[b]}
            + {{`CIM_WORD_WIDTH{1'b0}}, model_carry};
        case (op)
            OP_ORC:  model_rows[dst] = model_rows[a] | model_rows[b];
            OP_ANDC: model_rows[dst] = model_rows[a] & model_rows[b];
            OP_XORC: model_rows[dst] = model_rows[a] ^ model_rows[b];
            OP_ADDS:
            begin
                model_rows[dst] = sum[`CIM_WORD_WIDTH-1:0];
                model_carry     = sum[`CIM_WORD_WIDTH];
            end
            default: ;
        endcase
    endtask

    // carry value rides in the lsb of the src field
    task automatic issue_scin(input logic value);
        host_write('0, {OP_SCIN, 7'b0, value, 16'h0000});
        model_carry = value;
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic reset_and_loads();
        int   err_start;
        row_t rows [N_LOADS];
        err_start = errors;
        check_bit("avalon_waitrequest in reset", 1'b1, reset_waitreq);
        @(negedge sys_clk_in);
        check_bit("avalon_waitrequest after reset", 1'b0, avalon_waitrequest);
        // every row gets a known value first
        for (int r = 0; r < DEPTH; r++)
            load_row(row_t'(r), word_t'($urandom));
        for (int i = 0; i < N_LOADS; i++)
        begin
            rows[i] = row_t'($urandom);
            load_row(rows[i], word_t'($urandom));
        end
        for (int i = 0; i < N_LOADS; i++)
            check_row(rows[i]);
        check_word("readdatavalid pulse count", word_t'(reads_issued), word_t'(rdv_pulses));
        end_test("reset and loads", err_start);
    endtask

    task automatic single_row_ops();
        int         err_start;
        logic [7:0] ops [4];
        row_t       src;
        row_t       dst;
        logic [4:0] shamt;
        err_start = errors;
        ops = '{OP_MOVE, OP_PINV, OP_LSHFT, OP_RSHFT};
        for (int k = 0; k < 4; k++)
        begin
            for (int i = 0; i < N_SINGLE; i++)
            begin
                src = row_t'($urandom);
                // dst always differs so the source can be checked
                dst = ~src;
                // both shift extremes, then random amounts
                shamt = (i == 0) ? 5'd0 : ((i == 1) ? 5'd31 : 5'($urandom));
                issue_single(ops[k], src, dst, shamt);
                check_row(dst);
                check_row(src);
            end
        end
        end_test("single-row instructions", err_start);
    endtask

    task automatic dual_row_ops();
        int         err_start;
        logic [7:0] ops [3];
        row_t       a;
        row_t       b;
        row_t       dst;
        err_start = errors;
        ops = '{OP_ORC, OP_ANDC, OP_XORC};
        for (int k = 0; k < 3; k++)
        begin
            for (int i = 0; i < N_DUAL; i++)
            begin
                a   = row_t'($urandom);
                b   = row_t'($urandom);
                // dst over src_a, then over src_b
                dst = (i == 0) ? a : ((i == 1) ? b : row_t'($urandom));
                issue_dual(ops[k], a, b, dst);
                check_row(dst);
            end
        end
        end_test("two-row instructions", err_start);
    endtask

    task automatic carry_chain();
        int   err_start;
        row_t base;
        err_start = errors;
        base = row_t'($urandom);
        // msb set in both addends, so the first add overflows
        load_row(base, word_t'($urandom) | 32'h8000_0000);
        load_row(base ^ row_t'(1), word_t'($urandom) | 32'h8000_0000);
        load_row(base ^ row_t'(2), '0);
        load_row(base ^ row_t'(3), '0);
        issue_scin(1'b1);
        issue_dual(OP_ADDS, base, base ^ row_t'(1), base ^ row_t'(4));
        check_row(base ^ row_t'(4));
        // zero plus zero shows the carry out of the first add
        issue_dual(OP_ADDS, base ^ row_t'(2), base ^ row_t'(3), base ^ row_t'(5));
        check_row(base ^ row_t'(5));
        issue_scin(1'b1);
        issue_scin(1'b0);
        issue_dual(OP_ADDS, base, base ^ row_t'(1), base ^ row_t'(6));
        check_row(base ^ row_t'(6));
        end_test("carry arithmetic", err_start);
    endtask

    task automatic backpressure_and_unknown();
        int         err_start;
        logic [7:0] unknown_ops [N_UNKNOWN];
        row_t       x;
        row_t       src;
        row_t       dst;
        row_t       low;
        err_start = errors;
        unknown_ops = '{8'h02, 8'h07, 8'h20, 8'hFF};
        x = row_t'($urandom);
        // each request follows the last with no idle cycle
        load_row(x, word_t'($urandom));
        issue_single(OP_MOVE, x, ~x, 5'd0);
        checks++;
        assert (last_stall > 0)
        else
        begin
            $display("back-to-back request at %0d ns was not held by waitrequest", $time);
            errors++;
        end
        load_row(x, word_t'($urandom));
        issue_single(OP_PINV, x, x ^ row_t'(8'h55), 5'd0);
        check_row(~x);
        check_row(x ^ row_t'(8'h55));
        check_row(x);
        for (int i = 0; i < N_UNKNOWN; i++)
        begin
            src = row_t'($urandom);
            dst = row_t'($urandom);
            // low byte is dst in the two-row view
            low = row_t'($urandom);
            host_write('0, {unknown_ops[i], src, dst, low});
            check_row(src);
            check_row(dst);
            check_row(low);
        end
        end_test("back-pressure and unknown opcodes", err_start);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(SEED));
        sys_reset_in     = 1'b1;
        avalon_address   = '0;
        avalon_writedata = '0;
        avalon_write     = 1'b0;
        avalon_read      = 1'b0;
        model_carry      = 1'b0;
        repeat (RESET_CYCLES) @(negedge sys_clk_in);
        reset_waitreq = avalon_waitrequest;
        sys_reset_in  = 1'b0;
        reset_and_loads();
        single_row_ops();
        dual_row_ops();
        carry_chain();
        backpressure_and_unknown();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/cim_pkg.sv
design/cim_sequencer.sv
design/cim_array.sv
design/cim_row_alu.sv
design/cim_top.sv
sim/cim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cim testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cim_tb -f compile.f -o cim_sim

# a crashed or stopped simulation also counts as a failure
sim_out=$(./obj_dir/cim_sim) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'TB PASSED'
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
